//--- common/offload_pkg.sv
/*
  Shared types of the offload hub. The request carries an explicit operation,
  so no instruction decode is needed. At most 2**UnitSelWidth units can be
  addressed; each unit holds NumWords 32-bit configuration words.
*/
package offload_pkg;

  // --------------------------------------------------------------------
  // Field widths
  // --------------------------------------------------------------------

  // Unit address field, room for eight units
  localparam int unsigned UnitSelWidth = 3;
  localparam int unsigned MaxUnits     = 2 ** UnitSelWidth;

  // Configuration words per unit
  localparam int unsigned NumWords     = 8;
  localparam int unsigned WordIdxWidth = $clog2(NumWords);

  localparam int unsigned DataWidth    = 32;

  // Request id, echoed back with the response
  localparam int unsigned TagWidth     = 5;

  // --------------------------------------------------------------------
  // Scalar types
  // --------------------------------------------------------------------

  typedef logic [UnitSelWidth-1:0] unit_sel_t;
  typedef logic [WordIdxWidth-1:0] word_idx_t;
  typedef logic [DataWidth-1:0]    data_t;
  typedef logic [TagWidth-1:0]     tag_t;

  // Reads answer with data, writes stay silent
  typedef enum logic {
    OpRead  = 1'b0,
    OpWrite = 1'b1
  } acc_op_e;

  // --------------------------------------------------------------------
  // Stream payloads
  // --------------------------------------------------------------------

  // Core-side request, 44 bits
  typedef struct packed {
    unit_sel_t unit;
    acc_op_e   op;
    word_idx_t word;
    tag_t      tag;
    data_t     data;
  } acc_req_t;

  // Response back to the core, 38 bits
  typedef struct packed {
    tag_t  tag;
    data_t data;
    logic  error;
  } acc_rsp_t;

endpackage

//--- hw/offload_dispatch.sv
/*
  Steers each request to the unit named by its address field with no added
  latency. Addresses at or above NumUnits are absorbed here and answered with
  an error response one cycle later, whether they read or write.
*/
`timescale 1ns/1ps

module offload_dispatch #(
  parameter int unsigned NumUnits = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Core-side request stream
  input  offload_pkg::acc_req_t req_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  // Broadcast payload, one valid per unit
  output offload_pkg::acc_req_t unit_req_o,
  output logic [NumUnits-1:0]   unit_valid_o,
  input  logic [NumUnits-1:0]   unit_ready_i,
  // Error responses for unmapped addresses
  output offload_pkg::acc_rsp_t err_rsp_o,
  output logic                  err_valid_o,
  input  logic                  err_ready_i
);

  logic                in_range;
  logic [NumUnits-1:0] unit_hit;
  logic                unit_ready;
  logic                err_free;
  logic                err_accept;
  logic                err_valid_q;
  offload_pkg::tag_t   err_tag_q;

  // --------------------------------------------------------------------
  // Address decode
  // --------------------------------------------------------------------

  assign in_range = 32'(req_i.unit) < NumUnits;

  always_comb begin
    for (int unsigned k = 0; k < NumUnits; k++) begin
      unit_hit[k] = (req_i.unit == offload_pkg::unit_sel_t'(k));
    end
  end

  // Payload goes to every unit, only the addressed one sees valid
  assign unit_req_o   = req_i;
  assign unit_valid_o = unit_hit & {NumUnits{req_valid_i}};
  assign unit_ready   = |(unit_hit & unit_ready_i);

  assign req_ready_o = in_range ? unit_ready : err_free;

  // --------------------------------------------------------------------
  // Error response register
  // --------------------------------------------------------------------

  // Takes a new entry when empty or draining this cycle
  assign err_free   = !err_valid_q || err_ready_i;
  assign err_accept = req_valid_i && !in_range && err_free;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_valid_q <= 1'b0;
    end else if (err_accept) begin
      err_valid_q <= 1'b1;
    end else if (err_ready_i) begin
      err_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (err_accept) begin
      err_tag_q <= req_i.tag;
    end
  end

  assign err_valid_o = err_valid_q;
  assign err_rsp_o   = '{tag: err_tag_q, data: '0, error: 1'b1};

  // --------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------

  // Never more than one unit addressed at a time
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(unit_valid_o))
    else $error("dispatch raised more than one unit valid");

  // A stalled error response holds until taken
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    err_valid_o && !err_ready_i |=> err_valid_o && $stable(err_rsp_o))
    else $error("error response changed while stalled");

endmodule

//--- hw/cfg_unit.sv
/*
  One configuration-register unit of NumWords words, all zero after reset.
  Writes update a word and produce no response. A read answers one cycle
  after acceptance through a single response register.
*/
`timescale 1ns/1ps

module cfg_unit (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Request from the dispatcher
  input  offload_pkg::acc_req_t req_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  // Read response towards the arbiter
  output offload_pkg::acc_rsp_t rsp_o,
  output logic                  rsp_valid_o,
  input  logic                  rsp_ready_i
);

  offload_pkg::data_t [offload_pkg::NumWords-1:0] regs_q;

  logic               rsp_valid_q;
  offload_pkg::tag_t  rsp_tag_q;
  offload_pkg::data_t rsp_data_q;

  logic rsp_free;
  logic accept;
  logic is_read;

  // --------------------------------------------------------------------
  // Handshake
  // --------------------------------------------------------------------

  // Response slot is free when empty or drained this cycle.
  // A stalled read response blocks writes as well, which keeps
  // read-after-write order inside the unit simple.
  assign rsp_free    = !rsp_valid_q || rsp_ready_i;
  assign req_ready_o = rsp_free;

  assign accept  = req_valid_i && req_ready_o;
  assign is_read = (req_i.op == offload_pkg::OpRead);

  // --------------------------------------------------------------------
  // Register file
  // --------------------------------------------------------------------

  // Silent write on the accept edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      regs_q <= '0;
    end else if (accept && !is_read) begin
      regs_q[req_i.word] <= req_i.data;
    end
  end

  // --------------------------------------------------------------------
  // Read response register
  // --------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else if (accept && is_read) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // Word value as seen before any write in the same cycle
  always_ff @(posedge clk_i) begin
    if (accept && is_read) begin
      rsp_tag_q  <= req_i.tag;
      rsp_data_q <= regs_q[req_i.word];
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = '{tag: rsp_tag_q, data: rsp_data_q, error: 1'b0};

  // --------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------

  // Back-pressured response keeps its tag and data
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
    else $error("unit response changed while stalled");

endmodule

//--- hw/offload_arbiter.sv
/*
  Round-robin merge of NumInputs response streams into one registered output.
  Priority starts just after the last granted input. At most one input is
  granted per cycle, and only while the output register can take it.
*/
`timescale 1ns/1ps

module offload_arbiter #(
  parameter int unsigned NumInputs = 5
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // Response inputs, one per unit plus the error source
  input  offload_pkg::acc_rsp_t [NumInputs-1:0]  rsp_i,
  input  logic [NumInputs-1:0]                   rsp_valid_i,
  output logic [NumInputs-1:0]                   rsp_ready_o,
  // Merged response stream
  output offload_pkg::acc_rsp_t                  rsp_o,
  output logic                                   rsp_valid_o,
  input  logic                                   rsp_ready_i
);

  localparam int unsigned IdxWidth = (NumInputs > 1) ? $clog2(NumInputs) : 1;

  typedef logic [IdxWidth-1:0] idx_t;

  idx_t                  ptr_q;
  idx_t                  grant_idx;
  logic                  found;
  logic                  out_free;
  logic                  grant;
  logic                  out_valid_q;
  offload_pkg::acc_rsp_t out_q;

  // --------------------------------------------------------------------
  // Grant selection
  // --------------------------------------------------------------------

  // First valid input at or after the pointer, wrapping around
  always_comb begin
    int unsigned idx;
    found     = 1'b0;
    grant_idx = '0;
    for (int unsigned off = 0; off < NumInputs; off++) begin
      idx = int'(ptr_q) + off;
      if (idx >= NumInputs) begin
        idx = idx - NumInputs;
      end
      if (!found && rsp_valid_i[idx]) begin
        found     = 1'b1;
        grant_idx = idx_t'(idx);
      end
    end
  end

  assign out_free = !out_valid_q || rsp_ready_i;
  assign grant    = found && out_free;

  always_comb begin
    rsp_ready_o = '0;
    if (grant) begin
      rsp_ready_o[grant_idx] = 1'b1;
    end
  end

  // --------------------------------------------------------------------
  // Pointer and output stage
  // --------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q       <= '0;
      out_valid_q <= 1'b0;
    end else if (grant) begin
      ptr_q       <= (grant_idx == idx_t'(NumInputs - 1)) ? '0 : grant_idx + 1'b1;
      out_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant) begin
      out_q <= rsp_i[grant_idx];
    end
  end

  assign rsp_o       = out_q;
  assign rsp_valid_o = out_valid_q;

  // --------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------

  // Stalled output holds its payload until the consumer takes it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
    else $error("arbiter output changed while stalled");

endmodule

//--- hw/offload_hub.sv
/*
  Accelerator offload hub. Requests are demultiplexed to NumUnits config units
  (1 to 8), unmapped addresses get an error response. Read responses come back
  through a round-robin arbiter, at the earliest two cycles after acceptance.
*/
`timescale 1ns/1ps

module offload_hub #(
  parameter int unsigned NumUnits = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Core-side request stream
  input  offload_pkg::acc_req_t req_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  // Response stream back to the core
  output offload_pkg::acc_rsp_t rsp_o,
  output logic                  rsp_valid_o,
  input  logic                  rsp_ready_i
);

  // Units plus one error source
  localparam int unsigned NumInputs = NumUnits + 1;

  if (NumUnits < 1 || NumUnits > offload_pkg::MaxUnits) begin : gen_bad_num_units
    $fatal(1, "NumUnits must lie between 1 and 8");
  end

  offload_pkg::acc_req_t                 unit_req;
  logic [NumUnits-1:0]                   unit_valid;
  logic [NumUnits-1:0]                   unit_ready;
  offload_pkg::acc_rsp_t [NumInputs-1:0] arb_rsp;
  logic [NumInputs-1:0]                  arb_valid;
  logic [NumInputs-1:0]                  arb_ready;

  offload_dispatch #(
    .NumUnits (NumUnits)
  ) u_dispatch (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .unit_req_o   (unit_req),
    .unit_valid_o (unit_valid),
    .unit_ready_i (unit_ready),
    .err_rsp_o    (arb_rsp[NumUnits]),
    .err_valid_o  (arb_valid[NumUnits]),
    .err_ready_i  (arb_ready[NumUnits])
  );

  // Unit k answers on arbiter input k
  for (genvar k = 0; k < NumUnits; k++) begin : gen_units
    cfg_unit u_unit (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .req_i       (unit_req),
      .req_valid_i (unit_valid[k]),
      .req_ready_o (unit_ready[k]),
      .rsp_o       (arb_rsp[k]),
      .rsp_valid_o (arb_valid[k]),
      .rsp_ready_i (arb_ready[k])
    );
  end

  offload_arbiter #(
    .NumInputs (NumInputs)
  ) u_arbiter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rsp_i       (arb_rsp),
    .rsp_valid_i (arb_valid),
    .rsp_ready_o (arb_ready),
    .rsp_o       (rsp_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i)
  );

endmodule

//--- verif/offload_model.svh
/*
  Reference model of the offload hub, included inside the testbench module.
  The enclosing scope provides NumUnits, NumTags and check_equal.
  Unit addresses at or above NumUnits are modelled as error responses.
*/
`ifndef OFFLOAD_MODEL_SVH
`define OFFLOAD_MODEL_SVH

// Register copy per unit, updated on every accepted write
offload_pkg::data_t model_regs [NumUnits][offload_pkg::NumWords];

// Expected response and source per outstanding tag
offload_pkg::acc_rsp_t exp_rsp     [NumTags];
int                    exp_src     [NumTags];
bit                    outstanding [NumTags];

// Tags in acceptance order, one queue per unit plus one for errors
offload_pkg::tag_t order_q [NumUnits+1][$];
offload_pkg::tag_t free_tags [$];

int read_count;
int write_count;
int oor_count;
int rsp_count;

// Reads and unmapped addresses get an answer, unit writes do not
function automatic bit expects_response(offload_pkg::acc_req_t r);
  return (r.op == offload_pkg::OpRead) || (int'(r.unit) >= NumUnits);
endfunction

task automatic init_model();
  for (int u = 0; u < NumUnits; u++) begin
    for (int w = 0; w < offload_pkg::NumWords; w++) begin
      model_regs[u][w] = '0;
    end
  end
  for (int t = 0; t < NumTags; t++) begin
    outstanding[t] = 1'b0;
    free_tags.push_back(offload_pkg::tag_t'(t));
  end
endtask

// ----------------------------------------------------------------------
// Scoreboard
// ----------------------------------------------------------------------

task automatic record_request(offload_pkg::acc_req_t r);
  int                    u;
  int                    t;
  int                    src;
  offload_pkg::acc_rsp_t exp;
  u = int'(r.unit);
  t = int'(r.tag);
  if (u >= NumUnits) begin
    exp = '{tag: r.tag, data: '0, error: 1'b1};
    src = NumUnits;
    oor_count++;
  end else if (r.op == offload_pkg::OpWrite) begin
    model_regs[u][int'(r.word)] = r.data;
    write_count++;
    return;
  end else begin
    exp = '{tag: r.tag, data: model_regs[u][int'(r.word)], error: 1'b0};
    src = u;
    read_count++;
  end
  outstanding[t] = 1'b1;
  exp_rsp[t]     = exp;
  exp_src[t]     = src;
  order_q[src].push_back(r.tag);
endtask

task automatic retire_response(offload_pkg::acc_rsp_t r);
  int t;
  int src;
  t = int'(r.tag);
  rsp_count++;
  check_equal(64'(outstanding[t]), 64'd1, "response tag is outstanding");
  if (outstanding[t]) begin
    src = exp_src[t];
    // Oldest accepted tag of this source must come back first
    check_equal(64'(order_q[src][0]), 64'(r.tag), "response order within source");
    for (int i = 0; i < order_q[src].size(); i++) begin
      if (order_q[src][i] == r.tag) begin
        order_q[src].delete(i);
        break;
      end
    end
    check_equal(64'(r.data), 64'(exp_rsp[t].data), "response data");
    check_equal(64'(r.error), 64'(exp_rsp[t].error), "response error flag");
    outstanding[t] = 1'b0;
    free_tags.push_back(r.tag);
  end
endtask

`endif

//--- verif/tb_offload_hub.sv
/*
  Random testbench for the offload hub with four units. Unit addresses 4 to 7
  are out of range and must come back as errors. Responding requests take
  their tag from a pool of 32, so at most 32 answers are in flight.
*/
`timescale 1ns/1ps

module tb_offload_hub;

  localparam int NumUnits      = 4;
  localparam int NumTags       = 32;
  localparam int NumRequests   = 2000;
  localparam int TimeoutCycles = NumRequests * 40;

  logic                  clk_i = 1'b0;
  logic                  rst_ni;
  offload_pkg::acc_req_t req_i;
  logic                  req_valid_i;
  logic                  req_ready_o;
  offload_pkg::acc_rsp_t rsp_o;
  logic                  rsp_valid_o;
  logic                  rsp_ready_i;

  int                    error_count;
  int                    cycle_count;
  int                    issued;
  bit                    req_fired;
  bit                    have_next;
  offload_pkg::acc_req_t next_req;

  offload_hub #(
    .NumUnits (NumUnits)
  ) u_offload_hub (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .rsp_o       (rsp_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i)
  );

  // 40 ns period
  always #20 clk_i = ~clk_i;

  task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %0t ns %s: got 0x%0h, expected 0x%0h", $time, what, actual, expected);
    end
  endtask

  `include "offload_model.svh"

  task automatic print_counts();
    $display("Requests %0d, unit reads %0d, unit writes %0d, out of range %0d, %s %0d, errors %0d",
             issued, read_count, write_count, oor_count, "responses", rsp_count, error_count);
  endtask

  // ----------------------------------------------------------------------
  // Stimulus on the falling edge, sampling on the rising edge
  // ----------------------------------------------------------------------

  task automatic drive_inputs();
    if (req_fired) begin
      req_valid_i = 1'b0;
      req_fired   = 1'b0;
    end
    if (!req_valid_i && issued < NumRequests) begin
      if (!have_next) begin
        next_req.unit = offload_pkg::unit_sel_t'($urandom_range(0, 7));
        next_req.op   = ($urandom_range(0, 1) == 0) ? offload_pkg::OpRead : offload_pkg::OpWrite;
        next_req.word = offload_pkg::word_idx_t'($urandom_range(0, 7));
        next_req.tag  = offload_pkg::tag_t'($urandom_range(0, NumTags - 1));
        next_req.data = $urandom();
        have_next     = 1'b1;
      end
      // Held back while no tag is free
      if (!expects_response(next_req) || free_tags.size() > 0) begin
        if (expects_response(next_req)) begin
          next_req.tag = free_tags.pop_front();
        end
        req_i       = next_req;
        req_valid_i = 1'b1;
        have_next   = 1'b0;
        issued++;
      end
    end
    rsp_ready_i = ($urandom_range(0, 99) < 70);
  endtask

  task automatic sample_outputs();
    if (req_valid_i && req_ready_o) begin
      record_request(req_i);
      req_fired = 1'b1;
    end
    if (rsp_valid_o && rsp_ready_i) begin
      retire_response(rsp_o);
    end
  endtask

  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles, %0d tags still outstanding",
               TimeoutCycles, NumTags - free_tags.size());
      print_counts();
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'he717));
    rst_ni      = 1'b0;
    req_i       = '0;
    req_valid_i = 1'b0;
    rsp_ready_i = 1'b0;
    init_model();

    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    while (issued < NumRequests || req_valid_i || free_tags.size() != NumTags) begin
      @(negedge clk_i);
      drive_inputs();
      @(posedge clk_i);
      sample_outputs();
    end

    // Idle tail catches stray responses
    repeat (20) begin
      @(negedge clk_i);
      rsp_ready_i = 1'b1;
      @(posedge clk_i);
      sample_outputs();
    end

    check_equal(64'(rsp_count), 64'(read_count + oor_count), "total response count");

    print_counts();
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+verif
common/offload_pkg.sv
hw/offload_dispatch.sv
hw/cfg_unit.sv
hw/offload_arbiter.sv
hw/offload_hub.sv
verif/tb_offload_hub.sv

//--- run_sim.sh
#!/bin/sh
# Build the offload hub testbench with Verilator and run it.
# Exits non-zero unless the pass message shows up in the output.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
    --top-module tb_offload_hub -f sources.f; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_offload_hub)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TESTBENCH PASSED"; then
  exit 0
fi

echo "Simulation did not report a pass"
exit 1
